// ==== data_mem.sv ====
`timescale 1ns/100ps

module data_mem import lsu_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    dcache_req_if.responder mem
);

    logic [DATA_W-1:0]    mem_q [MEM_WORDS];
    logic [MEM_IDX_W-1:0] idx;
    logic                 rvalid_q;
    logic [DATA_W-1:0]    rdata_q;

    // word index from address bits 9 to 2
    assign idx = mem.addr[MEM_IDX_W+1:2];

    // no back-pressure
    assign mem.gnt    = mem.req;
    assign mem.rvalid = rvalid_q;
    assign mem.rdata  = rdata_q;

    // array and response flag
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_q    <= '{default: '0};
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= mem.req & ~mem.we;
            if (mem.req && mem.we) begin
                // merge only the enabled byte lanes
                for (int b = 0; b < BE_W; b++) begin
                    if (mem.be[b]) begin
                        mem_q[idx][8*b +: 8] <= mem.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // read data one cycle after the grant
    always_ff @(posedge clk_i) begin
        if (mem.req && !mem.we) begin
            rdata_q <= mem_q[idx];
        end
    end

endmodule

// ==== dcache_arbiter.sv ====
`timescale 1ns/100ps

module dcache_arbiter import lsu_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    dcache_req_if.responder st,
    dcache_req_if.responder ld,
    dcache_req_if.requester mem
);

    arb_sel_e last_q;
    logic     st_win;
    logic     ld_win;

    // on a tie the port that lost last time goes first
    assign st_win = st.req & (~ld.req | (last_q == SEL_LOAD));
    assign ld_win = ld.req & ~st_win;

    assign mem.req = st.req | ld.req;

    // steer the winner's payload
    always_comb begin
        if (st_win) begin
            mem.we    = st.we;
            mem.addr  = st.addr;
            mem.wdata = st.wdata;
            mem.be    = st.be;
        end else begin
            mem.we    = ld.we;
            mem.addr  = ld.addr;
            mem.wdata = ld.wdata;
            mem.be    = ld.be;
        end
    end

    assign st.gnt = st_win & mem.gnt;
    assign ld.gnt = ld_win & mem.gnt;

    // stores take no response
    assign st.rvalid = 1'b0;
    assign st.rdata  = '0;
    assign ld.rvalid = mem.rvalid;
    assign ld.rdata  = mem.rdata;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= SEL_LOAD;
        end else if (mem.req && mem.gnt) begin
            last_q <= st_win ? SEL_STORE : SEL_LOAD;
        end
    end

    // a tie right after a store grant goes to the load alone
    a_tie_to_load: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $past(st.gnt) && st.req && ld.req |-> ld.gnt && !st.gnt)
        else $error("arbiter: load lost a tie right after a store grant");

    // memory read data must belong to a load granted the cycle before
    a_rvalid_after_load: assert property (
        @(posedge clk_i) disable iff (!rst_ni) mem.rvalid |-> $past(ld.gnt))
        else $error("arbiter: read response without a load grant");

endmodule

// ==== dcache_req_if.sv ====
`timescale 1ns/100ps

interface dcache_req_if import lsu_pkg::*; ();

    // request side
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;

    // response side
    // gnt comes in the same cycle as req, rvalid one cycle after a read grant
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;

    modport requester (
        output req, we, addr, wdata, be,
        input  gnt, rvalid, rdata
    );

    modport responder (
        input  req, we, addr, wdata, be,
        output gnt, rvalid, rdata
    );

endinterface

// ==== load_unit.sv ====
`timescale 1ns/100ps

module load_unit import lsu_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                load_valid_i,
    input  logic [ADDR_W-1:0]   load_addr_i,
    // some buffered store shares the load's word offset
    input  logic                offset_match_i,
    output logic                load_ready_o,
    output logic                load_valid_o,
    output logic [DATA_W-1:0]   load_data_o,
    output logic [OFFSET_W-1:0] page_offset_o,
    dcache_req_if.requester     mem
);

    load_state_e       state_q;
    load_state_e       state_d;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] data_q;
    logic              valid_q;

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (load_valid_i) begin
                    state_d = WAIT_CONFLICT;
                end
            end
            // stay until matching stores drain or get flushed
            WAIT_CONFLICT: begin
                if (!offset_match_i) begin
                    state_d = REQUEST;
                end
            end
            REQUEST: begin
                if (mem.gnt) begin
                    state_d = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (mem.rvalid) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // one cycle result pulse
            valid_q <= (state_q == WAIT_DATA) & mem.rvalid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_valid_i && load_ready_o) begin
            addr_q <= load_addr_i;
        end
        if ((state_q == WAIT_DATA) && mem.rvalid) begin
            data_q <= mem.rdata;
        end
    end

    assign load_ready_o  = (state_q == IDLE);
    assign load_valid_o  = valid_q;
    assign load_data_o   = data_q;
    assign page_offset_o = addr_q[OFFSET_W-1:0];

    // read request, payload held stable until gnt
    assign mem.req   = (state_q == REQUEST);
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;
    assign mem.be    = '1;

    // read data only comes back for our own granted request
    a_rvalid_in_wait: assert property (
        @(posedge clk_i) disable iff (!rst_ni) mem.rvalid |-> (state_q == WAIT_DATA))
        else $error("load unit: rvalid outside WAIT_DATA");

endmodule

// ==== lsu_pkg.sv ====
package lsu_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------

    // physical address and data word
    localparam int unsigned ADDR_W = 16;
    localparam int unsigned DATA_W = 32;
    // one enable per byte lane
    localparam int unsigned BE_W = DATA_W / 8;

    // page offset of a load as seen by the store buffer checker
    localparam int unsigned OFFSET_W = 12;

    // ------------------------------------------------------------------------
    // depths
    // ------------------------------------------------------------------------

    localparam int unsigned DEPTH_SPEC = 4;
    localparam int unsigned DEPTH_COMMIT = 4;
    localparam int unsigned SPEC_PTR_W = $clog2(DEPTH_SPEC);
    localparam int unsigned COMMIT_PTR_W = $clog2(DEPTH_COMMIT);

    // data memory, word index taken from address bits 9 to 2
    localparam int unsigned MEM_WORDS = 256;
    localparam int unsigned MEM_IDX_W = $clog2(MEM_WORDS);

    // load unit FSM
    typedef enum logic [1:0] {
        IDLE,
        WAIT_CONFLICT,
        REQUEST,
        WAIT_DATA
    } load_state_e;

    // port that won the last granted memory cycle
    typedef enum logic {
        SEL_STORE,
        SEL_LOAD
    } arb_sel_e;

endpackage

// ==== store_buffer.sv ====
`timescale 1ns/100ps

module store_buffer import lsu_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    // drops every speculative entry, commit queue keeps draining
    input  logic                flush_i,
    // holds back the memory drain
    input  logic                stall_i,
    input  logic                valid_i,
    input  logic [ADDR_W-1:0]   addr_i,
    input  logic [DATA_W-1:0]   data_i,
    input  logic [BE_W-1:0]     be_i,
    input  logic                commit_i,
    input  logic [OFFSET_W-1:0] page_offset_i,
    output logic                ready_o,
    output logic                commit_ready_o,
    output logic                no_st_pending_o,
    output logic                store_buffer_empty_o,
    output logic                page_offset_matches_o,
    dcache_req_if.requester     mem
);

    // payload of one buffered store
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [BE_W-1:0]   be;
    } sb_entry_t;

    // speculative ring
    sb_entry_t               spec_ram_q [DEPTH_SPEC];
    logic [DEPTH_SPEC-1:0]   spec_valid_q;
    logic [SPEC_PTR_W-1:0]   spec_rd_ptr_q;
    logic [SPEC_PTR_W-1:0]   spec_wr_ptr_q;
    logic [SPEC_PTR_W:0]     spec_cnt_q;

    // commit ring
    sb_entry_t               commit_ram_q [DEPTH_COMMIT];
    logic [DEPTH_COMMIT-1:0] commit_valid_q;
    logic [COMMIT_PTR_W-1:0] commit_rd_ptr_q;
    logic [COMMIT_PTR_W-1:0] commit_wr_ptr_q;
    logic [COMMIT_PTR_W:0]   commit_cnt_q;

    logic                    push;
    logic                    drain;

    // flush wins over a push in the same cycle
    assign push  = valid_i & ~flush_i;
    assign drain = mem.req & mem.gnt;

    // ------------------------------------------------------------------------
    // status
    // ------------------------------------------------------------------------

    // a commit frees the head slot at the same edge
    assign ready_o              = (spec_cnt_q != DEPTH_SPEC) | commit_i;
    assign commit_ready_o       = (commit_cnt_q != DEPTH_COMMIT);
    assign no_st_pending_o      = (commit_cnt_q == '0);
    assign store_buffer_empty_o = (spec_cnt_q == '0) & no_st_pending_o;

    // ------------------------------------------------------------------------
    // speculative queue
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            spec_valid_q  <= '0;
            spec_rd_ptr_q <= '0;
            spec_wr_ptr_q <= '0;
            spec_cnt_q    <= '0;
        end else if (flush_i) begin
            spec_valid_q  <= '0;
            spec_wr_ptr_q <= spec_rd_ptr_q;
            spec_cnt_q    <= '0;
        end else begin
            // clear before set so a full queue can commit and push together
            if (commit_i) begin
                spec_valid_q[spec_rd_ptr_q] <= 1'b0;
                spec_rd_ptr_q               <= spec_rd_ptr_q + 1'b1;
            end
            if (push) begin
                spec_valid_q[spec_wr_ptr_q] <= 1'b1;
                spec_wr_ptr_q               <= spec_wr_ptr_q + 1'b1;
            end
            if (push && !commit_i) begin
                spec_cnt_q <= spec_cnt_q + 1'b1;
            end else if (commit_i && !push) begin
                spec_cnt_q <= spec_cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            spec_ram_q[spec_wr_ptr_q] <= '{addr: addr_i, data: data_i, be: be_i};
        end
    end

    // ------------------------------------------------------------------------
    // commit queue
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            commit_valid_q  <= '0;
            commit_rd_ptr_q <= '0;
            commit_wr_ptr_q <= '0;
            commit_cnt_q    <= '0;
        end else begin
            // head leaves on grant, memory takes the write at this edge
            if (drain) begin
                commit_valid_q[commit_rd_ptr_q] <= 1'b0;
                commit_rd_ptr_q                 <= commit_rd_ptr_q + 1'b1;
            end
            if (commit_i) begin
                commit_valid_q[commit_wr_ptr_q] <= 1'b1;
                commit_wr_ptr_q                 <= commit_wr_ptr_q + 1'b1;
            end
            if (commit_i && !drain) begin
                commit_cnt_q <= commit_cnt_q + 1'b1;
            end else if (drain && !commit_i) begin
                commit_cnt_q <= commit_cnt_q - 1'b1;
            end
        end
    end

    // speculative head moves over unchanged
    always_ff @(posedge clk_i) begin
        if (commit_i) begin
            commit_ram_q[commit_wr_ptr_q] <= spec_ram_q[spec_rd_ptr_q];
        end
    end

    // memory drain, writes only
    assign mem.req   = commit_valid_q[commit_rd_ptr_q] & ~stall_i;
    assign mem.we    = 1'b1;
    assign mem.addr  = commit_ram_q[commit_rd_ptr_q].addr;
    assign mem.wdata = commit_ram_q[commit_rd_ptr_q].data;
    assign mem.be    = commit_ram_q[commit_rd_ptr_q].be;

    // ------------------------------------------------------------------------
    // page offset checker
    // ------------------------------------------------------------------------

    // word granularity, bits 11 to 2, over both rings
    always_comb begin
        page_offset_matches_o = 1'b0;
        for (int i = 0; i < DEPTH_SPEC; i++) begin
            if (spec_valid_q[i] &&
                (spec_ram_q[i].addr[OFFSET_W-1:2] == page_offset_i[OFFSET_W-1:2])) begin
                page_offset_matches_o = 1'b1;
            end
        end
        for (int i = 0; i < DEPTH_COMMIT; i++) begin
            if (commit_valid_q[i] &&
                (commit_ram_q[i].addr[OFFSET_W-1:2] == page_offset_i[OFFSET_W-1:2])) begin
                page_offset_matches_o = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // assertions
    // ------------------------------------------------------------------------

    // flush and commit are decided in the same pipeline stage
    a_commit_and_flush: assert property (
        @(posedge clk_i) disable iff (!rst_ni) flush_i |-> !commit_i)
        else $error("store buffer: commit and flush in the same cycle");

    a_spec_overflow: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (spec_cnt_q == DEPTH_SPEC) && !commit_i |-> !valid_i)
        else $error("store buffer: push into a full speculative queue");

    a_spec_underflow: assert property (
        @(posedge clk_i) disable iff (!rst_ni) (spec_cnt_q == '0) |-> !commit_i)
        else $error("store buffer: commit from an empty speculative queue");

    a_commit_overflow: assert property (
        @(posedge clk_i) disable iff (!rst_ni) (commit_cnt_q == DEPTH_COMMIT) |-> !commit_i)
        else $error("store buffer: commit into a full commit queue");

endmodule

// ==== store_path_top.f ====
lsu_pkg.sv
dcache_req_if.sv
store_buffer.sv
load_unit.sv
dcache_arbiter.sv
data_mem.sv
store_path_top.sv
tb_store_path.sv

// ==== store_path_top.sv ====
`timescale 1ns/100ps

module store_path_top import lsu_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              stall_i,
    input  logic              st_valid_i,
    input  logic [ADDR_W-1:0] st_addr_i,
    input  logic [DATA_W-1:0] st_data_i,
    input  logic [BE_W-1:0]   st_be_i,
    input  logic              commit_i,
    input  logic              load_valid_i,
    input  logic [ADDR_W-1:0] load_addr_i,
    output logic              st_ready_o,
    output logic              commit_ready_o,
    output logic              no_st_pending_o,
    output logic              store_buffer_empty_o,
    output logic              load_ready_o,
    output logic              load_valid_o,
    output logic [DATA_W-1:0] load_data_o
);

    // store buffer and load unit on their own ports, arbiter merges them
    dcache_req_if st_port ();
    dcache_req_if ld_port ();
    dcache_req_if mem_port ();

    // load offset out, conflict flag back
    logic [OFFSET_W-1:0] page_offset;
    logic                offset_match;

    store_buffer i_store_buffer (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .stall_i               (stall_i),
        .valid_i               (st_valid_i),
        .addr_i                (st_addr_i),
        .data_i                (st_data_i),
        .be_i                  (st_be_i),
        .commit_i              (commit_i),
        .page_offset_i         (page_offset),
        .ready_o               (st_ready_o),
        .commit_ready_o        (commit_ready_o),
        .no_st_pending_o       (no_st_pending_o),
        .store_buffer_empty_o  (store_buffer_empty_o),
        .page_offset_matches_o (offset_match),
        .mem                   (st_port.requester)
    );

    load_unit i_load_unit (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .load_valid_i   (load_valid_i),
        .load_addr_i    (load_addr_i),
        .offset_match_i (offset_match),
        .load_ready_o   (load_ready_o),
        .load_valid_o   (load_valid_o),
        .load_data_o    (load_data_o),
        .page_offset_o  (page_offset),
        .mem            (ld_port.requester)
    );

    dcache_arbiter i_dcache_arbiter (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .st     (st_port.responder),
        .ld     (ld_port.responder),
        .mem    (mem_port.requester)
    );

    data_mem i_data_mem (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .mem    (mem_port.responder)
    );

endmodule

// ==== tb_store_path.sv ====
`timescale 1ns/100ps

module tb_store_path import lsu_pkg::*; ();

    localparam int unsigned TIMEOUT_CYCLES = 20000;
    localparam int unsigned RANDOM_OPS = 600;
    // random window, 16 words from word 64 up
    localparam logic [ADDR_W-1:0] WINDOW_BASE = 16'h0100;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [BE_W-1:0]   be;
    } store_t;

    logic              clk_i;
    logic              rst_ni;
    logic              flush_i;
    logic              stall_i;
    logic              st_valid_i;
    logic [ADDR_W-1:0] st_addr_i;
    logic [DATA_W-1:0] st_data_i;
    logic [BE_W-1:0]   st_be_i;
    logic              commit_i;
    logic              load_valid_i;
    logic [ADDR_W-1:0] load_addr_i;
    logic              st_ready_o;
    logic              commit_ready_o;
    logic              no_st_pending_o;
    logic              store_buffer_empty_o;
    logic              load_ready_o;
    logic              load_valid_o;
    logic [DATA_W-1:0] load_data_o;

    // reference model: memory contents and stores pushed but not yet committed
    logic [DATA_W-1:0] model_mem [MEM_WORDS];
    store_t            spec_model [$];
    logic [ADDR_W-1:0] load_addr;
    int unsigned       cycles = 0;
    int unsigned       loads_checked = 0;
    integer            seed = 32'hb45024cb;
    string             test_name;
    logic [31:0]       r;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;

    store_path_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // watchdog
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "simulation stopped by the watchdog");
        end
    end

    // ------------------------------------------------------------------------
    // checking helpers
    // ------------------------------------------------------------------------

    task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", test_name, msg);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    // only enabled lanes take the new bytes
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] word;
        word = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                word[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return word;
    endfunction

    // every load result against the model word, read at the negative edge
    always @(negedge clk_i) begin
        if (rst_ni && load_valid_o) begin
            check_word(test_name, model_mem[load_addr[9:2]], load_data_o);
            loads_checked++;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus tasks, one strobe cycle each
    // ------------------------------------------------------------------------

    task automatic push_store(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                              input logic [BE_W-1:0] be);
        @(posedge clk_i);
        st_valid_i <= 1'b1;
        st_addr_i  <= a;
        st_data_i  <= d;
        st_be_i    <= be;
        @(posedge clk_i);
        st_valid_i <= 1'b0;
        spec_model.push_back('{addr: a, data: d, be: be});
    endtask

    // committed stores count as memory contents from here on
    task automatic commit_head();
        store_t head;
        @(posedge clk_i);
        commit_i <= 1'b1;
        @(posedge clk_i);
        commit_i <= 1'b0;
        head = spec_model.pop_front();
        model_mem[head.addr[9:2]] = merge_bytes(model_mem[head.addr[9:2]], head.data, head.be);
    endtask

    task automatic flush_spec();
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        spec_model.delete();
    endtask

    // the monitor keeps the previous address until the result pulse is past
    task automatic issue_load(input logic [ADDR_W-1:0] a);
        @(posedge clk_i);
        load_addr = a;
        load_valid_i <= 1'b1;
        load_addr_i  <= a;
        @(posedge clk_i);
        load_valid_i <= 1'b0;
    endtask

    task automatic wait_load();
        @(negedge clk_i);
        while (!load_ready_o) begin
            @(negedge clk_i);
        end
    endtask

    task automatic load_and_check(input logic [ADDR_W-1:0] a,
                                  input logic [DATA_W-1:0] expected);
        issue_load(a);
        wait_load();
        check_word(test_name, expected, load_data_o);
    endtask

    task automatic wait_drained();
        @(negedge clk_i);
        while (!(no_st_pending_o && store_buffer_empty_o && load_ready_o)) begin
            @(negedge clk_i);
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        rst_ni       = 1'b0;
        flush_i      = 1'b0;
        stall_i      = 1'b0;
        st_valid_i   = 1'b0;
        st_addr_i    = '0;
        st_data_i    = '0;
        st_be_i      = '0;
        commit_i     = 1'b0;
        load_valid_i = 1'b0;
        load_addr_i  = '0;
        load_addr    = '0;
        test_name    = "reset";
        for (int w = 0; w < MEM_WORDS; w++) begin
            model_mem[w] = '0;
        end
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_word(test_name, 6'b111110, {st_ready_o, commit_ready_o, no_st_pending_o,
                                         store_buffer_empty_o, load_ready_o, load_valid_o});

        // full word, then a partial write merged into it
        test_name = "store_commit_load";
        push_store(16'h0010, 32'h1122_3344, 4'hf);
        commit_head();
        load_and_check(16'h0010, 32'h1122_3344);
        push_store(16'h0010, 32'haabb_ccdd, 4'b0110);
        commit_head();
        load_and_check(16'h0010, 32'h11bb_cc44);

        // committed store lands, flushed one never does
        test_name = "flush_discard";
        push_store(16'h0020, 32'h5555_0001, 4'hf);
        commit_head();
        push_store(16'h0024, 32'h6666_0002, 4'hf);
        flush_spec();
        load_and_check(16'h0024, 32'h0000_0000);
        load_and_check(16'h0020, 32'h5555_0001);

        // load on a buffered word stays blocked until the commit
        test_name = "load_waits";
        push_store(16'h0030, 32'h7777_0003, 4'hf);
        issue_load(16'h0030);
        repeat (10) @(negedge clk_i);
        assert (!load_ready_o) else report_failure("load finished while its word was buffered");
        commit_head();
        wait_load();
        check_word(test_name, 32'h7777_0003, load_data_o);

        // stalled drain fills the commit queue
        test_name = "stall_drain";
        wait_drained();
        @(posedge clk_i);
        stall_i <= 1'b1;
        for (int i = 0; i < DEPTH_COMMIT; i++) begin
            push_store(16'h0040 + 4 * i, 32'h8800_0000 + i, 4'hf);
            commit_head();
        end
        repeat (5) begin
            @(negedge clk_i);
            check_word(test_name, 3'b000,
                       {commit_ready_o, no_st_pending_o, store_buffer_empty_o});
        end
        @(posedge clk_i);
        stall_i <= 1'b0;
        // speculative queue is empty, so the whole buffer empties with the drain
        @(negedge clk_i);
        while (!no_st_pending_o) begin
            @(negedge clk_i);
        end
        check_word(test_name, 1'b1, store_buffer_empty_o);
        load_and_check(16'h004c, 32'h8800_0003);

        // full speculative queue drops ready, one commit frees a slot
        test_name = "spec_full";
        for (int i = 0; i < DEPTH_SPEC; i++) begin
            @(negedge clk_i);
            check_word(test_name, 1'b1, st_ready_o);
            push_store(16'h0050 + 4 * i, $random(seed), 4'hf);
        end
        @(negedge clk_i);
        check_word(test_name, 1'b0, st_ready_o);
        commit_head();
        @(negedge clk_i);
        check_word(test_name, 1'b1, st_ready_o);

        // random mix over the window, the monitor checks every load
        test_name = "random";
        for (int n = 0; n < RANDOM_OPS; n++) begin
            @(negedge clk_i);
            check_word("random st_ready_o", spec_model.size() < DEPTH_SPEC, st_ready_o);
            r    = $random(seed);
            data = $random(seed);
            addr = WINDOW_BASE + {r[7:4], 2'b00};
            if (r[3:0] < 6) begin
                // never write the word of a load that is past its conflict check
                if (st_ready_o && (load_ready_o || addr[9:2] != load_addr[9:2])) begin
                    push_store(addr, data, r[15:12]);
                end
            end else if (r[3:0] < 11) begin
                if (spec_model.size() > 0 && commit_ready_o) begin
                    commit_head();
                end
            end else if (r[3:0] < 15) begin
                if (load_ready_o) begin
                    issue_load(addr);
                end
            end else begin
                flush_spec();
            end
        end

        // commit what is left so a blocked load can finish
        while (spec_model.size() > 0) begin
            @(negedge clk_i);
            if (commit_ready_o) begin
                commit_head();
            end
        end
        wait_drained();
        test_name = "random_sweep";
        for (int k = 0; k < 16; k++) begin
            addr = WINDOW_BASE + 4 * k;
            load_and_check(addr, model_mem[addr[9:2]]);
        end
        assert (loads_checked > 16) else report_failure("too few load results were seen");

        $display("Test passed");
        $finish;
    end

endmodule
